//--- common/soc_bus_pkg.sv
// -----------------------------------------------
// System bus request/response types, address map
// and device indices
// -----------------------------------------------

package soc_bus_pkg;

  // Bus widths
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strobe_t;

  // Word index into the data RAM (8192 bytes / 4)
  typedef logic [10:0] ram_word_idx_t;

  // Manager request, also broadcast to the devices
  typedef struct packed {
    bus_addr_t   address;
    bus_data_t   write_data;
    bus_strobe_t write_strobe;
    logic        read_request;
    logic        write_request;
  } bus_req_t;

  // Response pulses, one cycle after the request
  typedef struct packed {
    bus_data_t read_data;
    logic      read_response;
    logic      write_response;
  } bus_rsp_t;

  // -----------------------------------------------
  // Device indices and address map
  // -----------------------------------------------
  localparam int NUM_DEVICES = 2;
  localparam int DEV_RAM     = 0;
  localparam int DEV_UART    = 1;

  typedef logic [$clog2(NUM_DEVICES)-1:0] dev_idx_t;

  localparam bus_addr_t RAM_BASE  = 32'h0000_0000;
  localparam bus_addr_t RAM_SIZE  = 32'd8192;
  localparam bus_addr_t UART_BASE = 32'h8000_0000;
  localparam bus_addr_t UART_SIZE = 32'd8;

endpackage

//--- common/uart_pkg.sv
// -----------------------------------------------
// UART register map, status bits, bit timing and
// transmit/receive state encodings
// -----------------------------------------------

package uart_pkg;

  // One bit lasts 8 clocks
  localparam int CLOCKS_PER_BIT = 8;

  // Register offsets within the 8-byte window
  typedef logic [2:0] reg_offset_t;

  localparam reg_offset_t REG_DATA   = 3'd0;
  localparam reg_offset_t REG_STATUS = 3'd4;

  // Status register bit positions
  localparam int STATUS_TX_BUSY  = 0;
  localparam int STATUS_RX_VALID = 1;

  typedef logic [7:0] uart_byte_t;
  typedef logic [2:0] bit_count_t;
  typedef logic [3:0] baud_count_t;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

//--- hw/system_bus.sv
// -----------------------------------------------
// Address decoder and response multiplexer for
// the single-manager system bus
// -----------------------------------------------

`timescale 1ns/1ps

module system_bus (
  input  logic                                        clock,
  input  logic                                        reset,
  input  soc_bus_pkg::bus_req_t                       host_req,
  output soc_bus_pkg::bus_rsp_t                       host_rsp,
  output soc_bus_pkg::bus_req_t                       dev_req,
  output logic [soc_bus_pkg::NUM_DEVICES-1:0]         dev_read_request,
  output logic [soc_bus_pkg::NUM_DEVICES-1:0]         dev_write_request,
  input  soc_bus_pkg::bus_rsp_t [soc_bus_pkg::NUM_DEVICES-1:0] dev_rsp
);

  logic [soc_bus_pkg::NUM_DEVICES-1:0] hit;
  logic                                hit_any;
  soc_bus_pkg::dev_idx_t               hit_idx;

  logic                  sel_valid_q;
  soc_bus_pkg::dev_idx_t sel_idx_q;
  logic                  unmapped_rd_q;
  logic                  unmapped_wr_q;

  function automatic logic in_region(soc_bus_pkg::bus_addr_t addr,
                                     soc_bus_pkg::bus_addr_t base,
                                     soc_bus_pkg::bus_addr_t size);
    soc_bus_pkg::bus_addr_t offset;
    offset = addr - base;
    return (addr >= base) && (offset < size);
  endfunction

  // -----------------------------------------------
  // Combinational decode
  // -----------------------------------------------
  always_comb begin
    hit = '0;
    hit[soc_bus_pkg::DEV_RAM] = in_region(host_req.address, soc_bus_pkg::RAM_BASE,
                                          soc_bus_pkg::RAM_SIZE);
    hit[soc_bus_pkg::DEV_UART] = in_region(host_req.address, soc_bus_pkg::UART_BASE,
                                           soc_bus_pkg::UART_SIZE);
  end

  always_comb begin
    hit_any = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < soc_bus_pkg::NUM_DEVICES; i++) begin
      if (hit[i]) begin
        hit_any = 1'b1;
        hit_idx = soc_bus_pkg::dev_idx_t'(i);
      end
    end
  end

  // Payload is shared, request bits go per device
  always_comb begin
    dev_req               = host_req;
    dev_req.read_request  = 1'b0;
    dev_req.write_request = 1'b0;
  end

  assign dev_read_request  = hit & {soc_bus_pkg::NUM_DEVICES{host_req.read_request}};
  assign dev_write_request = hit & {soc_bus_pkg::NUM_DEVICES{host_req.write_request}};

  // -----------------------------------------------
  // Remember who answers next cycle
  // -----------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sel_valid_q   <= 1'b0;
      sel_idx_q     <= '0;
      unmapped_rd_q <= 1'b0;
      unmapped_wr_q <= 1'b0;
    end else begin
      sel_valid_q   <= hit_any && (host_req.read_request || host_req.write_request);
      unmapped_rd_q <= !hit_any && host_req.read_request;
      unmapped_wr_q <= !hit_any && host_req.write_request;
      if (host_req.read_request || host_req.write_request) begin
        sel_idx_q <= hit_idx;
      end
    end
  end

  // Unmapped accesses get a zero-data answer from the bus
  always_comb begin
    host_rsp = '0;
    if (sel_valid_q) begin
      host_rsp = dev_rsp[sel_idx_q];
    end else begin
      host_rsp.read_response  = unmapped_rd_q;
      host_rsp.write_response = unmapped_wr_q;
    end
  end

endmodule

//--- hw/data_ram.sv
// -----------------------------------------------
// Word RAM with byte write strobes, one-cycle
// registered read response
// -----------------------------------------------

`timescale 1ns/1ps

module data_ram (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::bus_req_t req,
  input  logic                  read_request,
  input  logic                  write_request,
  output soc_bus_pkg::bus_rsp_t rsp
);

  soc_bus_pkg::bus_data_t mem [0:(soc_bus_pkg::RAM_SIZE/4)-1];

  soc_bus_pkg::ram_word_idx_t word_idx;
  soc_bus_pkg::bus_data_t     read_data_q;
  logic                       read_response_q;
  logic                       write_response_q;

  // Byte address to word index
  assign word_idx = soc_bus_pkg::ram_word_idx_t'(req.address >> 2);

  // -----------------------------------------------
  // Storage and read port
  // -----------------------------------------------
  always_ff @(posedge clock) begin
    if (write_request) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (req.write_strobe[lane]) begin
          mem[word_idx][8*lane +: 8] <= req.write_data[8*lane +: 8];
        end
      end
    end
    if (read_request) begin
      read_data_q <= mem[word_idx];
    end
  end

  // Response pulses
  always_ff @(posedge clock) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= read_request;
      write_response_q <= write_request;
    end
  end

  always_comb begin
    rsp.read_data      = read_data_q;
    rsp.read_response  = read_response_q;
    rsp.write_response = write_response_q;
  end

endmodule

//--- uart/uart_unit.sv
// -----------------------------------------------
// UART registers, transmit shifter, receive
// sampler and receive interrupt
// -----------------------------------------------

`timescale 1ns/1ps

module uart_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::bus_req_t req,
  input  logic                  read_request,
  input  logic                  write_request,
  output soc_bus_pkg::bus_rsp_t rsp,
  input  logic                  uart_rx,
  output logic                  uart_tx,
  output logic                  uart_irq
);

  uart_pkg::reg_offset_t  reg_offset;
  soc_bus_pkg::bus_data_t status_word;
  soc_bus_pkg::bus_data_t read_data_q;
  logic                   read_response_q;
  logic                   write_response_q;
  logic                   tx_load;
  logic                   rx_clear;
  logic                   tx_busy;

  uart_pkg::tx_state_t    tx_state;
  uart_pkg::uart_byte_t   tx_shift;
  uart_pkg::bit_count_t   tx_bit_cnt;
  uart_pkg::baud_count_t  tx_baud;
  logic                   tx_line;

  uart_pkg::rx_state_t    rx_state;
  logic [1:0]             rx_sync;
  uart_pkg::uart_byte_t   rx_shift;
  uart_pkg::uart_byte_t   rx_data;
  uart_pkg::bit_count_t   rx_bit_cnt;
  uart_pkg::baud_count_t  rx_baud;
  logic                   rx_valid;

  localparam uart_pkg::baud_count_t BIT_LAST =
    uart_pkg::baud_count_t'(uart_pkg::CLOCKS_PER_BIT - 1);
  localparam uart_pkg::baud_count_t HALF_LAST =
    uart_pkg::baud_count_t'(uart_pkg::CLOCKS_PER_BIT / 2 - 1);

  // -----------------------------------------------
  // Register block
  // -----------------------------------------------
  assign reg_offset = req.address[2:0];
  assign tx_busy    = (tx_state != uart_pkg::TX_IDLE);
  // A byte written while busy is acknowledged and lost
  assign tx_load    = write_request && (reg_offset == uart_pkg::REG_DATA) && !tx_busy;
  assign rx_clear   = read_request && (reg_offset == uart_pkg::REG_DATA);

  always_comb begin
    status_word = '0;
    status_word[uart_pkg::STATUS_TX_BUSY]  = tx_busy;
    status_word[uart_pkg::STATUS_RX_VALID] = rx_valid;
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      case (reg_offset)
        uart_pkg::REG_DATA:   read_data_q <= {24'd0, rx_data};
        uart_pkg::REG_STATUS: read_data_q <= status_word;
        default:              read_data_q <= '0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= read_request;
      write_response_q <= write_request;
    end
  end

  always_comb begin
    rsp.read_data      = read_data_q;
    rsp.read_response  = read_response_q;
    rsp.write_response = write_response_q;
  end

  // -----------------------------------------------
  // Transmit frame of start, 8 data bits LSB first and stop
  // -----------------------------------------------
  always_ff @(posedge clock) begin
    if (tx_load) begin
      tx_shift <= req.write_data[7:0];
    end else if (tx_state == uart_pkg::TX_DATA && tx_baud == BIT_LAST) begin
      tx_shift <= tx_shift >> 1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tx_state   <= uart_pkg::TX_IDLE;
      tx_line    <= 1'b1;
      tx_baud    <= '0;
      tx_bit_cnt <= '0;
    end else begin
      case (tx_state)
        uart_pkg::TX_IDLE: begin
          tx_baud <= '0;
          if (tx_load) begin
            tx_state <= uart_pkg::TX_START;
            tx_line  <= 1'b0;
          end
        end
        uart_pkg::TX_START: begin
          tx_baud <= tx_baud + 1'b1;
          if (tx_baud == BIT_LAST) begin
            tx_baud    <= '0;
            tx_bit_cnt <= '0;
            tx_line    <= tx_shift[0];
            tx_state   <= uart_pkg::TX_DATA;
          end
        end
        uart_pkg::TX_DATA: begin
          tx_baud <= tx_baud + 1'b1;
          if (tx_baud == BIT_LAST) begin
            tx_baud <= '0;
            if (tx_bit_cnt == uart_pkg::bit_count_t'(7)) begin
              tx_line  <= 1'b1;
              tx_state <= uart_pkg::TX_STOP;
            end else begin
              tx_bit_cnt <= tx_bit_cnt + 1'b1;
              tx_line    <= tx_shift[1];
            end
          end
        end
        default: begin
          tx_baud <= tx_baud + 1'b1;
          if (tx_baud == BIT_LAST) begin
            tx_state <= uart_pkg::TX_IDLE;
          end
        end
      endcase
    end
  end

  assign uart_tx = tx_line;

  // -----------------------------------------------
  // Receive sampler taking each bit at mid-bit
  // -----------------------------------------------
  always_ff @(posedge clock) begin
    if (rx_state == uart_pkg::RX_DATA && rx_baud == BIT_LAST) begin
      rx_shift <= {rx_sync[1], rx_shift[7:1]};
    end
    if (rx_state == uart_pkg::RX_STOP && rx_baud == BIT_LAST) begin
      rx_data <= rx_shift;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rx_sync    <= 2'b11;
      rx_state   <= uart_pkg::RX_IDLE;
      rx_baud    <= '0;
      rx_bit_cnt <= '0;
      rx_valid   <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], uart_rx};
      // Data read clears the flag unless a new byte lands in the same cycle
      if (rx_clear) begin
        rx_valid <= 1'b0;
      end
      case (rx_state)
        uart_pkg::RX_IDLE: begin
          rx_baud <= '0;
          if (!rx_sync[1]) begin
            rx_state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          rx_baud <= rx_baud + 1'b1;
          if (rx_baud == HALF_LAST) begin
            rx_baud    <= '0;
            rx_bit_cnt <= '0;
            // High again at mid-bit means a glitch
            rx_state   <= rx_sync[1] ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          rx_baud <= rx_baud + 1'b1;
          if (rx_baud == BIT_LAST) begin
            rx_baud    <= '0;
            rx_bit_cnt <= rx_bit_cnt + 1'b1;
            if (rx_bit_cnt == uart_pkg::bit_count_t'(7)) begin
              rx_state <= uart_pkg::RX_STOP;
            end
          end
        end
        default: begin
          rx_baud <= rx_baud + 1'b1;
          if (rx_baud == BIT_LAST) begin
            rx_valid <= 1'b1;
            rx_state <= uart_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

  // Interrupt level follows the unread byte
  assign uart_irq = rx_valid;

endmodule

//--- hw/soc_top.sv
// -----------------------------------------------
// Top level with host port, bus, RAM and UART
// -----------------------------------------------

`timescale 1ns/1ps

module soc_top (
  input  logic                  clock,
  input  logic                  reset,
  input  soc_bus_pkg::bus_req_t host_req,
  output soc_bus_pkg::bus_rsp_t host_rsp,
  input  logic                  uart_rx,
  output logic                  uart_tx,
  output logic                  uart_irq
);

  // Bus to devices
  soc_bus_pkg::bus_req_t                               dev_req;
  logic [soc_bus_pkg::NUM_DEVICES-1:0]                 dev_read_request;
  logic [soc_bus_pkg::NUM_DEVICES-1:0]                 dev_write_request;
  soc_bus_pkg::bus_rsp_t [soc_bus_pkg::NUM_DEVICES-1:0] dev_rsp;

  system_bus system_bus_inst (
    .clock             (clock),
    .reset             (reset),
    .host_req          (host_req),
    .host_rsp          (host_rsp),
    .dev_req           (dev_req),
    .dev_read_request  (dev_read_request),
    .dev_write_request (dev_write_request),
    .dev_rsp           (dev_rsp)
  );

  // -----------------------------------------------
  // Devices
  // -----------------------------------------------
  data_ram data_ram_inst (
    .clock         (clock),
    .reset         (reset),
    .req           (dev_req),
    .read_request  (dev_read_request[soc_bus_pkg::DEV_RAM]),
    .write_request (dev_write_request[soc_bus_pkg::DEV_RAM]),
    .rsp           (dev_rsp[soc_bus_pkg::DEV_RAM])
  );

  uart_unit uart_unit_inst (
    .clock         (clock),
    .reset         (reset),
    .req           (dev_req),
    .read_request  (dev_read_request[soc_bus_pkg::DEV_UART]),
    .write_request (dev_write_request[soc_bus_pkg::DEV_UART]),
    .rsp           (dev_rsp[soc_bus_pkg::DEV_UART]),
    .uart_rx       (uart_rx),
    .uart_tx       (uart_tx),
    .uart_irq      (uart_irq)
  );

endmodule

//--- dv/tb_clock_gen.sv
// --------------------------------------------------
// Testbench clock (20 ns) and 3-cycle reset
// --------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Released just after the third rising edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

//--- dv/soc_checker.sv
// --------------------------------------------------
// Response checker and independent uart_tx decoder
// --------------------------------------------------

`timescale 1ns/1ps

module soc_checker (
  input  logic                   clock,
  input  logic                   reset,
  input  soc_bus_pkg::bus_rsp_t  host_rsp,
  input  logic                   uart_tx,
  input  logic                   uart_irq,
  input  logic                   exp_valid,
  input  soc_bus_pkg::bus_data_t exp_data,
  input  logic [2:0]             exp_kind,
  output int                     check_count,
  output int                     error_count,
  output int                     pending_bytes
);

  localparam logic [2:0] KIND_WRITE  = 3'd0;
  localparam logic [2:0] KIND_READ   = 3'd1;
  localparam logic [2:0] KIND_STATUS = 3'd2;
  localparam logic [2:0] KIND_POLL   = 3'd3;
  localparam logic [2:0] KIND_SEND   = 3'd4;

  // Bytes expected on the serial line, in order
  uart_pkg::uart_byte_t tx_expect [0:63];
  int   push_count   = 0;
  int   pop_count    = 0;
  int   resp_checks  = 0;
  int   resp_errors  = 0;
  int   frame_checks = 0;
  int   frame_errors = 0;
  logic reset_q      = 1'b0;
  logic reset_bad    = 1'b0;

  assign check_count   = resp_checks + frame_checks;
  assign error_count   = resp_errors + frame_errors;
  assign pending_bytes = push_count - pop_count;

  task automatic check_response();
    logic is_write;
    is_write = (exp_kind == KIND_WRITE) || (exp_kind == KIND_SEND);
    if (is_write) begin
      resp_checks++;
      if (host_rsp.write_response !== 1'b1 || host_rsp.read_response !== 1'b0) begin
        resp_errors++;
        $display("Write at %0t ns got no single write response in the next cycle", $time);
      end else begin
        $display("Write acknowledged at %0t ns", $time);
        if (exp_kind == KIND_SEND) begin
          tx_expect[push_count] = exp_data[7:0];
          push_count++;
        end
      end
    end else if (host_rsp.read_response !== 1'b1 || host_rsp.write_response !== 1'b0) begin
      resp_checks++;
      resp_errors++;
      $display("Read at %0t ns got no single read response in the next cycle", $time);
    end else if (exp_kind != KIND_POLL) begin
      resp_checks++;
      if (host_rsp.read_data !== exp_data) begin
        resp_errors++;
        $display("Error at %0t ns: read 0x%08h, expected 0x%08h", $time,
                 host_rsp.read_data, exp_data);
      end else if (exp_kind == KIND_STATUS &&
                   uart_irq !== exp_data[uart_pkg::STATUS_RX_VALID]) begin
        resp_errors++;
        $display("Error at %0t ns: uart_irq is %b, expected %b", $time, uart_irq,
                 exp_data[uart_pkg::STATUS_RX_VALID]);
      end else begin
        $display("Read ok at %0t ns: 0x%08h", $time, host_rsp.read_data);
      end
    end
  endtask

  // --------------------------------------------------
  // Reset state and bus responses
  // --------------------------------------------------
  always @(posedge clock) begin
    if (reset_q) begin
      if (host_rsp.read_response !== 1'b0 || host_rsp.write_response !== 1'b0 ||
          uart_tx !== 1'b1 || uart_irq !== 1'b0) begin
        reset_bad = 1'b1;
      end
      // Last cycle still showing reset values
      if (!reset) begin
        resp_checks++;
        if (reset_bad) begin
          resp_errors++;
          $display("Reset state wrong: response pulse, uart_tx or uart_irq not at rest");
        end else begin
          $display("Reset state ok at %0t ns", $time);
        end
      end
    end
    reset_q = reset;
    if (exp_valid) begin
      check_response();
    end
  end

  task automatic check_frame(input uart_pkg::uart_byte_t frame, input logic stop_bit);
    frame_checks++;
    if (pop_count >= push_count) begin
      frame_errors++;
      $display("Frame 0x%02h appeared on uart_tx with no byte expected", frame);
    end else if (stop_bit !== 1'b1) begin
      frame_errors++;
      $display("Frame at %0t ns has no stop bit", $time);
    end else if (frame !== tx_expect[pop_count]) begin
      frame_errors++;
      $display("Error at %0t ns: uart_tx frame 0x%02h, expected 0x%02h", $time, frame,
               tx_expect[pop_count]);
    end else begin
      $display("Serial frame ok at %0t ns: 0x%02h", $time, frame);
    end
    if (pop_count < push_count) begin
      pop_count++;
    end
  endtask

  // --------------------------------------------------
  // Serial decoder, samples at mid-bit
  // --------------------------------------------------
  initial begin : serial_decoder
    uart_pkg::uart_byte_t frame;
    logic                 stop_bit;
    forever begin
      @(posedge clock);
      if (reset === 1'b0 && uart_tx === 1'b0) begin
        repeat (uart_pkg::CLOCKS_PER_BIT / 2) @(posedge clock);
        for (int i = 0; i < 8; i++) begin
          repeat (uart_pkg::CLOCKS_PER_BIT) @(posedge clock);
          frame[i] = uart_tx;
        end
        repeat (uart_pkg::CLOCKS_PER_BIT) @(posedge clock);
        stop_bit = uart_tx;
        check_frame(frame, stop_bit);
      end
    end
  end

endmodule

//--- dv/soc_sva.sv
// --------------------------------------------------
// Bus response timing and UART idle line assertions
// --------------------------------------------------

`timescale 1ns/1ps

module soc_sva #(
  parameter bit CHECK_TX_LINE = 1'b1
) (
  input logic clock,
  input logic reset,
  input logic rd_req,
  input logic wr_req,
  input logic rd_rsp,
  input logic wr_rsp,
  input logic tx_idle,
  input logic tx_line
);

  int failures = 0;

  // Each request gets exactly one response in the next cycle
  read_follows: assert property (@(posedge clock) disable iff (reset)
    rd_req |=> rd_rsp && !wr_rsp) else begin
    failures++;
    $error("read request not answered by one read response in the next cycle");
  end

  write_follows: assert property (@(posedge clock) disable iff (reset)
    wr_req |=> wr_rsp && !rd_rsp) else begin
    failures++;
    $error("write request not answered by one write response in the next cycle");
  end

  // Nothing answers without a request
  no_stray_read: assert property (@(posedge clock) disable iff (reset)
    rd_rsp |-> $past(rd_req)) else begin
    failures++;
    $error("read response without a read request");
  end

  no_stray_write: assert property (@(posedge clock) disable iff (reset)
    wr_rsp |-> $past(wr_req)) else begin
    failures++;
    $error("write response without a write request");
  end

  // Only where a transmit FSM is present
  if (CHECK_TX_LINE) begin : tx_line_checks
    tx_line_idle: assert property (@(posedge clock) disable iff (reset)
      tx_idle |-> tx_line) else begin
      failures++;
      $error("uart_tx low while the transmit FSM is idle");
    end
  end

endmodule

bind system_bus soc_sva #(.CHECK_TX_LINE(1'b0)) bus_sva (
  .clock   (clock),
  .reset   (reset),
  .rd_req  (host_req.read_request),
  .wr_req  (host_req.write_request),
  .rd_rsp  (host_rsp.read_response),
  .wr_rsp  (host_rsp.write_response),
  .tx_idle (1'b0),
  .tx_line (1'b1)
);

bind uart_unit soc_sva #(.CHECK_TX_LINE(1'b1)) uart_sva (
  .clock   (clock),
  .reset   (reset),
  .rd_req  (read_request),
  .wr_req  (write_request),
  .rd_rsp  (rsp.read_response),
  .wr_rsp  (rsp.write_response),
  .tx_idle (tx_state == uart_pkg::TX_IDLE),
  .tx_line (uart_tx)
);

//--- dv/soc_tb.sv
// --------------------------------------------------
// Testbench top: trace reader, host port driver,
// UART loopback and timeout
// --------------------------------------------------

`timescale 1ns/1ps

module soc_tb;

  localparam int         CYCLES_PER_OP = 120;
  localparam logic [2:0] KIND_WRITE    = 3'd0;
  localparam logic [2:0] KIND_READ     = 3'd1;
  localparam logic [2:0] KIND_STATUS   = 3'd2;
  localparam logic [2:0] KIND_POLL     = 3'd3;
  localparam logic [2:0] KIND_SEND     = 3'd4;

  logic                   clock;
  logic                   reset;
  soc_bus_pkg::bus_req_t  host_req;
  soc_bus_pkg::bus_rsp_t  host_rsp;
  logic                   uart_line;
  logic                   uart_irq;
  logic                   exp_valid;
  soc_bus_pkg::bus_data_t exp_data;
  logic [2:0]             exp_kind;
  int                     check_count;
  int                     error_count;
  int                     pending_bytes;

  // Trace columns
  logic [7:0]               op_q     [$];
  soc_bus_pkg::bus_addr_t   addr_q   [$];
  soc_bus_pkg::bus_data_t   data_q   [$];
  soc_bus_pkg::bus_strobe_t strobe_q [$];
  soc_bus_pkg::bus_data_t   expect_q [$];
  int trace_errors = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;

  tb_clock_gen clock_gen (
    .clock (clock),
    .reset (reset)
  );

  // Serial loopback through uart_line
  soc_top UUT (
    .clock    (clock),
    .reset    (reset),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .uart_rx  (uart_line),
    .uart_tx  (uart_line),
    .uart_irq (uart_irq)
  );

  soc_checker soc_checker_inst (
    .clock         (clock),
    .reset         (reset),
    .host_rsp      (host_rsp),
    .uart_tx       (uart_line),
    .uart_irq      (uart_irq),
    .exp_valid     (exp_valid),
    .exp_data      (exp_data),
    .exp_kind      (exp_kind),
    .check_count   (check_count),
    .error_count   (error_count),
    .pending_bytes (pending_bytes)
  );

  task automatic load_trace();
    int                       fd;
    int                       fields;
    string                    line;
    logic [7:0]               op;
    soc_bus_pkg::bus_addr_t   addr;
    soc_bus_pkg::bus_data_t   data;
    soc_bus_pkg::bus_strobe_t strobe;
    soc_bus_pkg::bus_data_t   expected;
    fd = $fopen("dv/soc_trace.txt", "r");
    if (fd == 0) begin
      trace_errors++;
      $display("Could not open the trace file dv/soc_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        fields = $sscanf(line, "%s %h %h %h %h", op, addr, data, strobe, expected);
        if (fields == 5 && op != "#") begin
          op_q.push_back(op);
          addr_q.push_back(addr);
          data_q.push_back(data);
          strobe_q.push_back(strobe);
          expect_q.push_back(expected);
        end
      end
      $fclose(fd);
    end
  endtask

  // One request pulse, then wait for its response
  task automatic bus_access(input logic is_write, input soc_bus_pkg::bus_addr_t addr,
                            input soc_bus_pkg::bus_data_t wdata,
                            input soc_bus_pkg::bus_strobe_t strobe, input logic [2:0] kind,
                            input soc_bus_pkg::bus_data_t expected,
                            output soc_bus_pkg::bus_data_t rdata);
    host_req.address       = addr;
    host_req.write_data    = wdata;
    host_req.write_strobe  = strobe;
    host_req.read_request  = !is_write;
    host_req.write_request = is_write;
    @(posedge clock);
    #1;
    host_req.read_request  = 1'b0;
    host_req.write_request = 1'b0;
    exp_kind               = kind;
    exp_data               = expected;
    exp_valid              = 1'b1;
    do begin
      @(posedge clock);
    end while (host_rsp.read_response !== 1'b1 && host_rsp.write_response !== 1'b1);
    rdata = host_rsp.read_data;
    #1;
    exp_valid = 1'b0;
  endtask

  task automatic poll_until_idle(input soc_bus_pkg::bus_addr_t addr);
    soc_bus_pkg::bus_data_t rdata;
    do begin
      bus_access(1'b0, addr, '0, '0, KIND_POLL, '0, rdata);
    end while (rdata[uart_pkg::STATUS_TX_BUSY] !== 1'b0);
  endtask

  task automatic wait_for_irq();
    do begin
      @(posedge clock);
    end while (uart_irq !== 1'b1);
    #1;
  endtask

  task automatic report_result();
    int sva_failures;
    sva_failures = UUT.system_bus_inst.bus_sva.failures +
                   UUT.uart_unit_inst.uart_sva.failures;
    $display("Checks: %0d, errors: %0d, trace errors: %0d, assertion failures: %0d",
             check_count, error_count, trace_errors, sva_failures);
    if (error_count == 0 && trace_errors == 0 && sva_failures == 0 &&
        pending_bytes == 0 && check_count > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // --------------------------------------------------
  // Trace execution
  // --------------------------------------------------
  initial begin : run_trace
    soc_bus_pkg::bus_data_t rdata;
    logic [2:0]             kind;
    host_req  = '0;
    exp_valid = 1'b0;
    exp_data  = '0;
    exp_kind  = KIND_WRITE;
    load_trace();
    cycle_limit = (op_q.size() + 1) * CYCLES_PER_OP;
    do begin
      @(posedge clock);
    end while (reset !== 1'b0);
    #1;
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": bus_access(1'b1, addr_q[i], data_q[i], strobe_q[i], KIND_WRITE, expect_q[i],
                        rdata);
        "R": begin
          kind = (addr_q[i] == soc_bus_pkg::UART_BASE +
                  soc_bus_pkg::bus_addr_t'(uart_pkg::REG_STATUS)) ? KIND_STATUS : KIND_READ;
          bus_access(1'b0, addr_q[i], '0, '0, kind, expect_q[i], rdata);
        end
        "T": bus_access(1'b1, addr_q[i], data_q[i], strobe_q[i], KIND_SEND, data_q[i], rdata);
        "P": poll_until_idle(addr_q[i]);
        "I": wait_for_irq();
        default: begin
          trace_errors++;
          $display("Unknown trace operation %c in entry %0d", op_q[i], i);
        end
      endcase
    end
    // Let queued frames leave the line
    while (pending_bytes != 0) begin
      @(posedge clock);
    end
    report_result();
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the trace did not complete", cycle_count);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

//--- dv/soc_trace.txt
# op address data strobe expected (hex)
# W write, R read and compare, T send byte, P poll until idle, I wait for irq
W 00000000 11223344 f 00000000
W 00000004 a5a5a5a5 f 00000000
W 00000010 deadbeef f 00000000
W 00001ffc cafef00d f 00000000
W 00000000 000000ee 1 00000000
W 00000004 77660000 c 00000000
W 00000010 0000aa00 2 00000000
R 00000000 00000000 0 112233ee
R 00000004 00000000 0 7766a5a5
R 00000010 00000000 0 deadaaef
R 00001ffc 00000000 0 cafef00d
R 00004000 00000000 0 00000000
R 40000000 00000000 0 00000000
W 00002000 12345678 f 00000000
R 00000000 00000000 0 112233ee
T 80000000 00000041 1 00000000
R 80000004 00000000 0 00000001
P 80000004 00000000 0 00000000
I 00000000 00000000 0 00000000
R 80000004 00000000 0 00000002
R 80000000 00000000 0 00000041
R 80000004 00000000 0 00000000
T 80000000 0000005a 1 00000000
W 80000000 000000c3 1 00000000
R 80000004 00000000 0 00000001
P 80000004 00000000 0 00000000
I 00000000 00000000 0 00000000
R 80000000 00000000 0 0000005a
R 80000004 00000000 0 00000000

//--- compile.f
common/soc_bus_pkg.sv
common/uart_pkg.sv
hw/system_bus.sv
hw/data_ram.sv
uart/uart_unit.sv
hw/soc_top.sv
dv/tb_clock_gen.sv
dv/soc_checker.sv
dv/soc_sva.sv
dv/soc_tb.sv

//--- Makefile
# Verilator simulation of the SoC testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass if $(LOG) holds the pass message"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module soc_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vsoc_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
